// File: list.f
verilog/segPkg.sv
verilog/bgLayerMatch.sv
verilog/fgDecide.sv
verilog/bgColorUpdate.sv
verilog/bgWeightUpdate.sv
verilog/segOutReg.sv
verilog/segCore.sv
testbench/segChecker.sv
testbench/tbSegCore.sv

// File: run.sh
#!/bin/bash
# build and run the segCore testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tbSegCore -f list.f -o simSegCore \
  && ./obj_dir/simSegCore > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "RESULT: PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: testbench/tbSegCore.sv
`timescale 1ns/1ps

module tbSegCore import segPkg::*; ();

  localparam int NUM_DIRECTED = 6;
  localparam int NUM_ROWS = NUM_DIRECTED + 16;

  typedef struct {
    pixel_t thY, thU, thV;
    weight_t bgTh, step;
    logic upd;
    pixel_t cY, cU, cV;
    layerVec_t lY, lU, lV, lW;
    layerVec_t eY, eU, eV, eW;
    logic eM;
  } row_t;

  row_t rows[NUM_ROWS];
  logic clk, arstN, update, mask, expMask, expValid;
  pixel_t thY, thU, thV, curY, curU, curV;
  weight_t bgTh, buildStep;
  layerVec_t layY, layU, layV, layW, newY, newU, newV, newW;
  layerVec_t expY, expU, expV, expW;
  int testId, testCount, errorCount, waitCycles;
  logic [31:0] lfsr = 32'he20c_aa84;

  segCore i_dut (
    .clk_i(clk), .arstN_i(arstN), .bdThY_i(thY), .bdThU_i(thU), .bdThV_i(thV),
    .bgTh_i(bgTh), .update_i(update), .buildStep_i(buildStep),
    .curY_i(curY), .curU_i(curU), .curV_i(curV),
    .bgLayerY_i(layY), .bgLayerU_i(layU), .bgLayerV_i(layV), .bgLayerW_i(layW),
    .newLayerY_o(newY), .newLayerU_o(newU), .newLayerV_o(newV), .newLayerW_o(newW),
    .mask_o(mask)
  );

  segChecker i_checker (
    .clk_i(clk), .dutY_i(newY), .dutU_i(newU), .dutV_i(newV), .dutW_i(newW),
    .dutMask_i(mask), .expY_i(expY), .expU_i(expU), .expV_i(expV), .expW_i(expW),
    .expMask_i(expMask), .expValid_i(expValid), .testId_i(testId),
    .testCount_o(testCount), .errorCount_o(errorCount)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // taps 32 22 2 1 and one step per bit taken
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  function automatic pixel_t stepToward(input pixel_t bg, input pixel_t cur);
    if (cur > bg) return bg + 8'd1;
    if (cur < bg) return bg - 8'd1;
    return bg;
  endfunction

  function automatic int absDiff(input pixel_t a, input pixel_t b);
    return (a > b) ? int'(a) - int'(b) : int'(b) - int'(a);
  endfunction

  // expected outputs straight from the matching and update rules
  task automatic computeModel(inout row_t r);
    int win;
    int w;
    win  = -1;
    r.eM = 1'b1;
    r.eY = r.lY;
    r.eU = r.lU;
    r.eV = r.lV;
    r.eW = r.lW;
    for (int i = 0; i < 4; i++) begin
      if (absDiff(r.cY, r.lY[i*8 +: 8]) < r.thY && absDiff(r.cU, r.lU[i*8 +: 8]) < r.thU &&
          absDiff(r.cV, r.lV[i*8 +: 8]) < r.thV) begin
        win = i;
        if (r.lW[i*8 +: 8] > r.bgTh) r.eM = 1'b0;
      end
    end
    for (int i = 0; i < 4; i++) begin
      w = r.lW[i*8 +: 8];
      if (i == win) begin
        r.eW[i*8 +: 8] = (w + r.step < 255) ? w + r.step : w;
        r.eY[i*8 +: 8] = stepToward(r.lY[i*8 +: 8], r.cY);
        r.eU[i*8 +: 8] = stepToward(r.lU[i*8 +: 8], r.cU);
        r.eV[i*8 +: 8] = stepToward(r.lV[i*8 +: 8], r.cV);
      end else begin
        r.eW[i*8 +: 8] = (w == 0) ? 0 : w - 1;
      end
    end
    if (win < 0) begin
      r.eY[7:0] = r.cY;
      r.eU[7:0] = r.cU;
      r.eV[7:0] = r.cV;
      r.eW[7:0] = 8'd0;
    end
    if (!r.upd) begin
      r.eY = r.lY;
      r.eU = r.lU;
      r.eV = r.lV;
      r.eW = r.lW;
    end
  endtask

  // directed rows use thresholds of 10 with background threshold 100 and step 8
  task automatic makeRow(input int k, input logic upd, input pixel_t cY, input pixel_t cU,
                         input pixel_t cV, input layerVec_t lY, input layerVec_t lU,
                         input layerVec_t lV, input layerVec_t lW, input layerVec_t eY,
                         input layerVec_t eU, input layerVec_t eV, input layerVec_t eW,
                         input logic eM);
    rows[k] = '{8'd10, 8'd10, 8'd10, 8'd100, 8'd8, upd, cY, cU, cV,
                lY, lU, lV, lW, eY, eU, eV, eW, eM};
  endtask

  task automatic applyRow(input int k);
    thY = rows[k].thY;
    thU = rows[k].thU;
    thV = rows[k].thV;
    bgTh = rows[k].bgTh;
    buildStep = rows[k].step;
    update = rows[k].upd;
    curY = rows[k].cY;
    curU = rows[k].cU;
    curV = rows[k].cV;
    layY = rows[k].lY;
    layU = rows[k].lU;
    layV = rows[k].lV;
    layW = rows[k].lW;
    expY = rows[k].eY;
    expU = rows[k].eU;
    expV = rows[k].eV;
    expW = rows[k].eW;
    expMask = rows[k].eM;
    expValid = 1'b1;
    testId = k + 1;
  endtask

  initial begin
    row_t r;
    arstN = 1'b0;
    {thY, thU, thV, bgTh, buildStep, curY, curU, curV} = '0;
    {layY, layU, layV, layW} = '0;
    update = 1'b0;
    {expY, expU, expV, expW} = '0;
    expMask = 1'b0;
    expValid = 1'b0;
    testId = 0;

    // no match and the zero weight in layer 2 stays zero
    makeRow(0, 1, 8'd50, 8'd60, 8'd70, 32'hC8C8C8C8, 32'hC8C8C8C8, 32'hC8C8C8C8,
            32'h0500030A, 32'hC8C8C832, 32'hC8C8C83C, 32'hC8C8C846, 32'h04000200, 1);
    // layers 0 and 1 match and layer 1 wins and grows
    makeRow(1, 1, 8'd100, 8'd100, 8'd100, 32'hC8C8695F, 32'h00006464, 32'h00006464,
            32'h00012050, 32'hC8C8685F, 32'h00006464, 32'h00006464, 32'h0000284F, 1);
    // winner weight of exactly 255 minus step is held and clears the mask
    makeRow(2, 1, 8'd100, 8'd100, 8'd100, 32'hC8C8695F, 32'h00006464, 32'h00006464,
            32'h0001F750, 32'hC8C8685F, 32'h00006464, 32'h00006464, 32'h0000F74F, 0);
    // weight equal to the threshold is still foreground
    makeRow(3, 1, 8'd100, 8'd100, 8'd100, 32'hC8C8C864, 32'h00000064, 32'h00000064,
            32'h00000064, 32'hC8C8C864, 32'h00000064, 32'h00000064, 32'h0000006C, 1);
    // difference equal to the threshold does not match
    makeRow(4, 1, 8'd100, 8'd100, 8'd100, 32'hC8C8C86E, 32'h00000064, 32'h00000064,
            32'h000000C8, 32'hC8C8C864, 32'h00000064, 32'h00000064, 32'h00000000, 1);
    // update off passes the vectors while the mask is still decided
    makeRow(5, 0, 8'd100, 8'd100, 8'd100, 32'hC8C8695F, 32'h00006464, 32'h00006464,
            32'h0001F850, 32'hC8C8695F, 32'h00006464, 32'h00006464, 32'h0001F850, 0);

    for (int k = NUM_DIRECTED; k < NUM_ROWS; k++) begin
      r.thY = randBits(4) + 1;
      r.thU = randBits(4) + 1;
      r.thV = randBits(4) + 1;
      r.bgTh = randBits(8);
      r.step = randBits(4);
      r.upd = randBits(1);
      r.cY = randBits(8);
      r.cU = randBits(8);
      r.cV = randBits(8);
      // layers near the pixel so that matches happen often
      for (int i = 0; i < 4; i++) begin
        r.lY[i*8 +: 8] = r.cY + pixel_t'(randBits(5)) - 8'd16;
        r.lU[i*8 +: 8] = r.cU + pixel_t'(randBits(4)) - 8'd8;
        r.lV[i*8 +: 8] = r.cV + pixel_t'(randBits(4)) - 8'd8;
        r.lW[i*8 +: 8] = randBits(8);
      end
      computeModel(r);
      rows[k] = r;
    end

    // stimulus during reset must come out as zero
    repeat (3) @(posedge clk);
    #1;
    curY = 8'd77;
    layW = 32'h11223344;
    update = 1'b1;
    expValid = 1'b1;
    @(posedge clk);
    #1;
    arstN = 1'b1;
    for (int k = 0; k < NUM_ROWS; k++) begin
      applyRow(k);
      @(posedge clk);
      #1;
    end
    expValid = 1'b0;

    waitCycles = 0;
    while (testCount < NUM_ROWS + 1 && waitCycles < 10) begin
      @(posedge clk);
      waitCycles++;
    end
    if (testCount < NUM_ROWS + 1) begin
      $display("timeout, the checker finished only %0d of %0d tests", testCount,
               NUM_ROWS + 1);
    end
    $display("tests %0d, errors %0d", testCount, errorCount);
    if (errorCount == 0 && testCount == NUM_ROWS + 1) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: testbench/segChecker.sv
`timescale 1ns/1ps

module segChecker import segPkg::*; (
  input  logic      clk_i,
  input  layerVec_t dutY_i,
  input  layerVec_t dutU_i,
  input  layerVec_t dutV_i,
  input  layerVec_t dutW_i,
  input  logic      dutMask_i,
  input  layerVec_t expY_i,
  input  layerVec_t expU_i,
  input  layerVec_t expV_i,
  input  layerVec_t expW_i,
  input  logic      expMask_i,
  input  logic      expValid_i,
  input  int        testId_i,
  output int        testCount_o,
  output int        errorCount_o
);

  layerVec_t pendY;
  layerVec_t pendU;
  layerVec_t pendV;
  layerVec_t pendW;
  logic      pendMask;
  logic      pendValid;
  int        pendId;

  initial begin
    testCount_o  = 0;
    errorCount_o = 0;
    pendValid    = 1'b0;
  end

  // expected values ride along with the edge that samples the stimulus
  always @(posedge clk_i) begin
    pendY     <= expY_i;
    pendU     <= expU_i;
    pendV     <= expV_i;
    pendW     <= expW_i;
    pendMask  <= expMask_i;
    pendValid <= expValid_i;
    pendId    <= testId_i;
  end

  task automatic compareVec(input string name, input layerVec_t got, input layerVec_t exp,
                            inout int bad);
    if (got !== exp) begin
      $display("ERROR %0t: test %0d %s got %h expected %h", $time, pendId, name, got, exp);
      bad++;
    end
  endtask

  // outputs settle after the rising edge, compare in mid cycle
  always @(negedge clk_i) begin
    int bad;
    bad = 0;
    if (pendValid) begin
      compareVec("layerY", dutY_i, pendY, bad);
      compareVec("layerU", dutU_i, pendU, bad);
      compareVec("layerV", dutV_i, pendV, bad);
      compareVec("weight", dutW_i, pendW, bad);
      if (dutMask_i !== pendMask) begin
        $display("ERROR %0t: test %0d mask got %b expected %b", $time, pendId, dutMask_i,
                 pendMask);
        bad++;
      end
      $display("test %0d finished, %0d mismatches", pendId, bad);
      errorCount_o = errorCount_o + bad;
      testCount_o  = testCount_o + 1;
    end
  end

endmodule

// File: verilog/segCore.sv
`timescale 1ns/1ps

module segCore import segPkg::*; (
  input  logic      clk_i,
  input  logic      arstN_i,
  input  pixel_t    bdThY_i,
  input  pixel_t    bdThU_i,
  input  pixel_t    bdThV_i,
  input  weight_t   bgTh_i,
  input  logic      update_i,
  input  weight_t   buildStep_i,
  input  pixel_t    curY_i,
  input  pixel_t    curU_i,
  input  pixel_t    curV_i,
  input  layerVec_t bgLayerY_i,
  input  layerVec_t bgLayerU_i,
  input  layerVec_t bgLayerV_i,
  input  layerVec_t bgLayerW_i,
  output layerVec_t newLayerY_o,
  output layerVec_t newLayerU_o,
  output layerVec_t newLayerV_o,
  output layerVec_t newLayerW_o,
  output logic      mask_o
);

  layerMask_t matched;
  layerMask_t winner;
  logic       maskComb;
  layerVec_t  updY;
  layerVec_t  updU;
  layerVec_t  updV;
  layerVec_t  updW;

  // one match test per layer
  for (genvar g = 0; g < NUM_LAYERS; g++) begin : gLayer
    bgLayerMatch i_match (
      .curY_i    (curY_i),
      .curU_i    (curU_i),
      .curV_i    (curV_i),
      .bgY_i     (bgLayerY_i[g*PIX_W +: PIX_W]),
      .bgU_i     (bgLayerU_i[g*PIX_W +: PIX_W]),
      .bgV_i     (bgLayerV_i[g*PIX_W +: PIX_W]),
      .thY_i     (bdThY_i),
      .thU_i     (bdThU_i),
      .thV_i     (bdThV_i),
      .matched_o (matched[g])
    );
  end

  fgDecide i_decide (
    .matched_i  (matched),
    .bgLayerW_i (bgLayerW_i),
    .bgTh_i     (bgTh_i),
    .mask_o     (maskComb),
    .winner_o   (winner)
  );

  // same update rule for each colour channel
  bgColorUpdate i_updY (
    .winner_i (winner),
    .cur_i    (curY_i),
    .layer_i  (bgLayerY_i),
    .layer_o  (updY)
  );

  bgColorUpdate i_updU (
    .winner_i (winner),
    .cur_i    (curU_i),
    .layer_i  (bgLayerU_i),
    .layer_o  (updU)
  );

  bgColorUpdate i_updV (
    .winner_i (winner),
    .cur_i    (curV_i),
    .layer_i  (bgLayerV_i),
    .layer_o  (updV)
  );

  bgWeightUpdate i_updW (
    .winner_i    (winner),
    .buildStep_i (buildStep_i),
    .weight_i    (bgLayerW_i),
    .weight_o    (updW)
  );

  segOutReg i_outReg (
    .clk_i       (clk_i),
    .arstN_i     (arstN_i),
    .update_i    (update_i),
    .mask_i      (maskComb),
    .updY_i      (updY),
    .updU_i      (updU),
    .updV_i      (updV),
    .updW_i      (updW),
    .orgY_i      (bgLayerY_i),
    .orgU_i      (bgLayerU_i),
    .orgV_i      (bgLayerV_i),
    .orgW_i      (bgLayerW_i),
    .newLayerY_o (newLayerY_o),
    .newLayerU_o (newLayerU_o),
    .newLayerV_o (newLayerV_o),
    .newLayerW_o (newLayerW_o),
    .mask_o      (mask_o)
  );

endmodule

// File: verilog/segOutReg.sv
`timescale 1ns/1ps

module segOutReg import segPkg::*; (
  input  logic      clk_i,
  input  logic      arstN_i,
  input  logic      update_i,
  input  logic      mask_i,
  input  layerVec_t updY_i,
  input  layerVec_t updU_i,
  input  layerVec_t updV_i,
  input  layerVec_t updW_i,
  input  layerVec_t orgY_i,
  input  layerVec_t orgU_i,
  input  layerVec_t orgV_i,
  input  layerVec_t orgW_i,
  output layerVec_t newLayerY_o,
  output layerVec_t newLayerU_o,
  output layerVec_t newLayerV_o,
  output layerVec_t newLayerW_o,
  output logic      mask_o
);

  layerVec_t selY;
  layerVec_t selU;
  layerVec_t selV;
  layerVec_t selW;

  // update disabled passes the original background through
  assign selY = update_i ? updY_i : orgY_i;
  assign selU = update_i ? updU_i : orgU_i;
  assign selV = update_i ? updV_i : orgV_i;
  assign selW = update_i ? updW_i : orgW_i;

  always_ff @(posedge clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      newLayerY_o <= '0;
      newLayerU_o <= '0;
      newLayerV_o <= '0;
      newLayerW_o <= '0;
      mask_o      <= 1'b0;
    end else begin
      newLayerY_o <= selY;
      newLayerU_o <= selU;
      newLayerV_o <= selV;
      newLayerW_o <= selW;
      // mask follows the rules even with update off
      mask_o      <= mask_i;
    end
  end

endmodule

// File: verilog/bgWeightUpdate.sv
`timescale 1ns/1ps

module bgWeightUpdate import segPkg::*; (
  input  layerMask_t winner_i,
  input  weight_t    buildStep_i,
  input  layerVec_t  weight_i,
  output layerVec_t  weight_o
);

  weight_t growLimit;

  // growing is allowed only while the sum stays below the maximum
  assign growLimit = WEIGHT_MAX - buildStep_i;

  always_comb begin
    weight_t w;
    weight_t wNew;

    w        = '0;
    wNew     = '0;
    weight_o = '0;

    for (int i = 0; i < NUM_LAYERS; i++) begin
      w = weight_i[i*PIX_W +: PIX_W];
      if (winner_i[i]) begin
        wNew = (w < growLimit) ? (w + buildStep_i) : w;
      end else begin
        // decay, saturating at zero
        wNew = (w == '0) ? '0 : (w - 1'b1);
      end
      weight_o[i*PIX_W +: PIX_W] = wNew;
    end

    // no match, layer 0 was replaced by the pixel and starts from zero
    if (winner_i == '0) begin
      weight_o[PIX_W-1:0] = '0;
    end
  end

endmodule

// File: verilog/bgColorUpdate.sv
`timescale 1ns/1ps

module bgColorUpdate import segPkg::*; (
  input  layerMask_t winner_i,
  input  pixel_t     cur_i,
  input  layerVec_t  layer_i,
  output layerVec_t  layer_o
);

  always_comb begin
    pixel_t bgVal;
    pixel_t stepVal;

    bgVal   = '0;
    stepVal = '0;
    layer_o = layer_i;

    if (winner_i == '0) begin
      // nothing matched, layer 0 restarts from the pixel
      layer_o[PIX_W-1:0] = cur_i;
    end else begin
      for (int i = 0; i < NUM_LAYERS; i++) begin
        if (winner_i[i]) begin
          bgVal = layer_i[i*PIX_W +: PIX_W];
          // one step toward the pixel, hold when equal
          if (cur_i > bgVal) begin
            stepVal = bgVal + 1'b1;
          end else if (cur_i < bgVal) begin
            stepVal = bgVal - 1'b1;
          end else begin
            stepVal = bgVal;
          end
          layer_o[i*PIX_W +: PIX_W] = stepVal;
        end
      end
    end
  end

endmodule

// File: verilog/fgDecide.sv
`timescale 1ns/1ps

module fgDecide import segPkg::*; (
  input  layerMask_t matched_i,
  input  layerVec_t  bgLayerW_i,
  input  weight_t    bgTh_i,
  output logic       mask_o,
  output layerMask_t winner_o
);

  layerMask_t strongMatch;

  // a matched layer counts as background only above the threshold
  always_comb begin
    for (int i = 0; i < NUM_LAYERS; i++) begin
      strongMatch[i] = matched_i[i] && (bgLayerW_i[i*PIX_W +: PIX_W] > bgTh_i);
    end
  end

  assign mask_o = ~(|strongMatch);

  // highest matching layer wins, later iterations override lower ones
  always_comb begin
    winner_o = '0;
    for (int i = 0; i < NUM_LAYERS; i++) begin
      if (matched_i[i]) begin
        winner_o    = '0;
        winner_o[i] = 1'b1;
      end
    end
  end

endmodule

// File: verilog/bgLayerMatch.sv
`timescale 1ns/1ps

module bgLayerMatch import segPkg::*; (
  input  pixel_t curY_i,
  input  pixel_t curU_i,
  input  pixel_t curV_i,
  input  pixel_t bgY_i,
  input  pixel_t bgU_i,
  input  pixel_t bgV_i,
  input  pixel_t thY_i,
  input  pixel_t thU_i,
  input  pixel_t thV_i,
  output logic   matched_o
);

  pixel_t diffY;
  pixel_t diffU;
  pixel_t diffV;

  // absolute difference per channel, never wraps
  assign diffY = (curY_i > bgY_i) ? (curY_i - bgY_i) : (bgY_i - curY_i);
  assign diffU = (curU_i > bgU_i) ? (curU_i - bgU_i) : (bgU_i - curU_i);
  assign diffV = (curV_i > bgV_i) ? (curV_i - bgV_i) : (bgV_i - curV_i);

  // strictly below, a difference equal to the threshold is no match
  assign matched_o = (diffY < thY_i) && (diffU < thU_i) && (diffV < thV_i);

endmodule

// File: verilog/segPkg.sv
package segPkg;

  // four background layers per pixel
  localparam int NUM_LAYERS = 4;

  // width of one channel sample or one weight
  localparam int PIX_W = 8;

  // one channel sample or match threshold
  typedef logic [PIX_W-1:0] pixel_t;

  // one layer weight
  typedef logic [PIX_W-1:0] weight_t;

  // one channel of all layers, layer 0 in the low byte
  typedef logic [NUM_LAYERS*PIX_W-1:0] layerVec_t;

  // one bit per layer, match flags or one-hot winner
  typedef logic [NUM_LAYERS-1:0] layerMask_t;

  // weight saturates here
  localparam weight_t WEIGHT_MAX = 8'd255;

endpackage
